// ==== rtl/core_pkg.sv ====
package core_pkg;

   localparam int INSTR_W    = 16;
   localparam int NREGS      = 8;
   localparam int REG_ADDR_W = 3;
   localparam int OP_W       = 3;
   localparam int IMM_W      = 8;
   localparam int DATA_W     = 16;   // Retire data field, default core width

   // Codes 7 and up decode as a no-op
   typedef enum logic [OP_W-1:0] {
      OP_ADD = 3'd0,
      OP_SUB = 3'd1,
      OP_AND = 3'd2,
      OP_OR  = 3'd3,
      OP_XOR = 3'd4,
      OP_LDI = 3'd5,
      OP_MUL = 3'd6
   } opcode_e;

   // Register form, two sources
   typedef struct packed {
      logic [REG_ADDR_W-1:0]                     rs1;
      logic [REG_ADDR_W-1:0]                     rs2;
      logic [INSTR_W-OP_W-3*REG_ADDR_W-1:0]      unused;
   } reg_args_t;

   // LDI form, immediate in the low byte
   typedef struct packed {
      logic [INSTR_W-OP_W-REG_ADDR_W-IMM_W-1:0]  unused;
      logic [IMM_W-1:0]                          imm;
   } imm_args_t;

   typedef union packed {
      reg_args_t rr;
      imm_args_t ri;
   } instr_args_t;

   typedef struct packed {
      opcode_e               opcode;   // Bits 15:13
      logic [REG_ADDR_W-1:0] rd;       // Bits 12:10
      instr_args_t           args;
   } instr_t;

   // Fixed part of the WIDTH-dependent stage packets.
   // Issue packet is valid, op, rd, a, b, imm in that order
   localparam int ISSUE_HDR_W  = 1 + OP_W + REG_ADDR_W + IMM_W;
   // Result packet is valid, rd, data
   localparam int RESULT_HDR_W = 1 + REG_ADDR_W;
   // Multiply step is valid, rd, multiplicand, multiplier, partial sum
   localparam int STEP_HDR_W   = 1 + REG_ADDR_W;

   // Qualified by retire_valid
   typedef struct packed {
      logic [REG_ADDR_W-1:0] dest;
      logic [DATA_W-1:0]     data;
   } retire_t;

endpackage

// ==== rtl/regfile.sv ====
`timescale 1ns/100ps

module regfile #(
   parameter int WIDTH = 16
) (
   input  logic                            clk,
   input  logic                            rst,
   input  logic [core_pkg::REG_ADDR_W-1:0] rd_addr_a,
   input  logic [core_pkg::REG_ADDR_W-1:0] rd_addr_b,
   input  logic                            wr_en,
   input  logic [core_pkg::REG_ADDR_W-1:0] wr_addr,
   input  logic [WIDTH-1:0]                wr_data,
   output logic [WIDTH-1:0]                rd_data_a,
   output logic [WIDTH-1:0]                rd_data_b
);
   import core_pkg::*;

   logic [WIDTH-1:0] regs [NREGS];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_addr] <= wr_data;
      end
   end

   // No bypass, a reader waits until the write edge has passed
   assign rd_data_a = regs[rd_addr_a];
   assign rd_data_b = regs[rd_addr_b];

endmodule

// ==== rtl/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage #(
   parameter int WIDTH      = 16,
   parameter int MUL_STAGES = 4
) (
   input  logic                                     clk,
   input  logic                                     rst,
   input  logic                                     instr_valid,
   input  core_pkg::instr_t                         instr,
   output logic                                     stall,
   output logic [core_pkg::REG_ADDR_W-1:0]          rd_addr_a,
   output logic [core_pkg::REG_ADDR_W-1:0]          rd_addr_b,
   input  logic [WIDTH-1:0]                         rd_data_a,
   input  logic [WIDTH-1:0]                         rd_data_b,
   input  logic                                     wr_en,
   input  logic [core_pkg::REG_ADDR_W-1:0]          wr_addr,
   output logic [core_pkg::ISSUE_HDR_W+2*WIDTH-1:0] alu_issue,
   output logic [core_pkg::ISSUE_HDR_W+2*WIDTH-1:0] mul_issue
);
   import core_pkg::*;

   typedef struct packed {
      logic                  valid;
      opcode_e               op;
      logic [REG_ADDR_W-1:0] rd;
      logic [WIDTH-1:0]      a;
      logic [WIDTH-1:0]      b;
      logic [IMM_W-1:0]      imm;
   } issue_t;

   // Slot that an ALU op accepted now would share with a multiply
   localparam logic [MUL_STAGES-1:0] ALU_SLOT = MUL_STAGES'(2);

   logic                  is_alu;
   logic                  is_mul;
   logic                  writes_rd;
   logic                  reads_regs;
   logic                  src_busy;
   logic                  rd_busy;
   logic                  slot_busy;
   logic                  accept;
   logic [NREGS-1:0]      pending;     // Scoreboard, one bit per register
   logic [MUL_STAGES-1:0] mul_slots;   // Bit k: multiply result reaches retire k+1 edges on
   logic                  alu_valid;
   logic                  mul_valid;
   issue_t                issue_q;     // Shared payload, only one path valid
   issue_t                alu_pkt;
   issue_t                mul_pkt;

   always_comb begin
      is_alu = 1'b0;
      is_mul = 1'b0;
      case (instr.opcode)
         OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_LDI: is_alu = 1'b1;
         OP_MUL: is_mul = 1'b1;
         default: ;   // No-op
      endcase
   end

   assign writes_rd  = is_alu || is_mul;
   assign reads_regs = writes_rd && (instr.opcode != OP_LDI);
   assign rd_addr_a  = instr.args.rr.rs1;
   assign rd_addr_b  = instr.args.rr.rs2;

   assign src_busy  = reads_regs && (pending[rd_addr_a] || pending[rd_addr_b]);
   assign rd_busy   = writes_rd && pending[instr.rd];
   assign slot_busy = is_alu && |(mul_slots & ALU_SLOT);
   assign stall     = instr_valid && (src_busy || rd_busy || slot_busy);
   assign accept    = instr_valid && !stall;

   always_ff @(posedge clk) begin
      if (rst) begin
         pending   <= '0;
         mul_slots <= '0;
         alu_valid <= 1'b0;
         mul_valid <= 1'b0;
      end else begin
         if (wr_en) pending[wr_addr] <= 1'b0;
         if (accept && writes_rd) pending[instr.rd] <= 1'b1;   // rd never pending here
         mul_slots <= mul_slots >> 1;
         if (accept && is_mul) mul_slots[MUL_STAGES-1] <= 1'b1;
         alu_valid <= accept && is_alu;
         mul_valid <= accept && is_mul;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         issue_q.valid <= 1'b1;
         issue_q.op    <= instr.opcode;
         issue_q.rd    <= instr.rd;
         issue_q.a     <= rd_data_a;
         issue_q.b     <= rd_data_b;
         issue_q.imm   <= instr.args.ri.imm;
      end
   end

   always_comb begin
      alu_pkt       = issue_q;
      alu_pkt.valid = alu_valid;
      mul_pkt       = issue_q;
      mul_pkt.valid = mul_valid;
   end

   assign alu_issue = alu_pkt;
   assign mul_issue = mul_pkt;

endmodule

// ==== rtl/alu_stage.sv ====
`timescale 1ns/100ps

module alu_stage #(
   parameter int WIDTH = 16
) (
   input  logic                                     clk,
   input  logic                                     rst,
   input  logic [core_pkg::ISSUE_HDR_W+2*WIDTH-1:0] alu_issue,
   output logic [core_pkg::RESULT_HDR_W+WIDTH-1:0]  alu_res
);
   import core_pkg::*;

   typedef struct packed {
      logic                  valid;
      opcode_e               op;
      logic [REG_ADDR_W-1:0] rd;
      logic [WIDTH-1:0]      a;
      logic [WIDTH-1:0]      b;
      logic [IMM_W-1:0]      imm;
   } issue_t;

   typedef struct packed {
      logic                  valid;
      logic [REG_ADDR_W-1:0] rd;
      logic [WIDTH-1:0]      data;
   } result_t;

   issue_t           iss;
   logic [WIDTH-1:0] value;
   result_t          res_q;

   assign iss = alu_issue;

   always_comb begin
      case (iss.op)
         OP_ADD:  value = iss.a + iss.b;    // Wraps
         OP_SUB:  value = iss.a - iss.b;
         OP_AND:  value = iss.a & iss.b;
         OP_OR:   value = iss.a | iss.b;
         OP_XOR:  value = iss.a ^ iss.b;
         OP_LDI:  value = WIDTH'(iss.imm);  // Zero-extended
         default: value = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      res_q.rd   <= iss.rd;
      res_q.data <= value;
      if (rst) res_q.valid <= 1'b0;
      else     res_q.valid <= iss.valid;
   end

   assign alu_res = res_q;

endmodule

// ==== rtl/mul_stage.sv ====
`timescale 1ns/100ps

module mul_stage #(
   parameter int WIDTH      = 16,
   parameter int MUL_STAGES = 4
) (
   input  logic                                    clk,
   input  logic                                    rst,
   input  logic [core_pkg::STEP_HDR_W+3*WIDTH-1:0] in_step,
   output logic [core_pkg::STEP_HDR_W+3*WIDTH-1:0] out_step
);
   import core_pkg::*;

   localparam int BITS = WIDTH / MUL_STAGES;   // Multiplier bits per step

   typedef struct packed {
      logic                  valid;
      logic [REG_ADDR_W-1:0] rd;
      logic [WIDTH-1:0]      mcand;    // Already shifted by earlier steps
      logic [WIDTH-1:0]      mplier;   // Bits not yet consumed, LSB first
      logic [WIDTH-1:0]      sum;
   } step_t;

   step_t            in_s;
   step_t            out_q;
   logic [WIDTH-1:0] acc;

   assign in_s = in_step;

   // Product bits above WIDTH are dropped
   always_comb begin
      acc = in_s.sum;
      for (int j = 0; j < BITS; j++) begin
         if (in_s.mplier[j]) acc = acc + (in_s.mcand << j);
      end
   end

   always_ff @(posedge clk) begin
      out_q.rd     <= in_s.rd;
      out_q.mcand  <= in_s.mcand << BITS;
      out_q.mplier <= in_s.mplier >> BITS;
      out_q.sum    <= acc;
      if (rst) out_q.valid <= 1'b0;
      else     out_q.valid <= in_s.valid;
   end

   assign out_step = out_q;

endmodule

// ==== rtl/mul_pipe.sv ====
`timescale 1ns/100ps

module mul_pipe #(
   parameter int WIDTH      = 16,
   parameter int MUL_STAGES = 4
) (
   input  logic                                     clk,
   input  logic                                     rst,
   input  logic [core_pkg::ISSUE_HDR_W+2*WIDTH-1:0] mul_issue,
   output logic [core_pkg::RESULT_HDR_W+WIDTH-1:0]  mul_res
);
   import core_pkg::*;

   typedef struct packed {
      logic                  valid;
      opcode_e               op;
      logic [REG_ADDR_W-1:0] rd;
      logic [WIDTH-1:0]      a;
      logic [WIDTH-1:0]      b;
      logic [IMM_W-1:0]      imm;
   } issue_t;

   typedef struct packed {
      logic                  valid;
      logic [REG_ADDR_W-1:0] rd;
      logic [WIDTH-1:0]      data;
   } result_t;

   typedef struct packed {
      logic                  valid;
      logic [REG_ADDR_W-1:0] rd;
      logic [WIDTH-1:0]      mcand;
      logic [WIDTH-1:0]      mplier;
      logic [WIDTH-1:0]      sum;
   } step_t;

   issue_t  iss;
   step_t   first;
   step_t   last_s;
   result_t res;
   logic [STEP_HDR_W+3*WIDTH-1:0] chain [MUL_STAGES+1];

   assign iss = mul_issue;

   always_comb begin
      first.valid  = iss.valid;
      first.rd     = iss.rd;
      first.mcand  = iss.a;
      first.mplier = iss.b;
      first.sum    = '0;
   end

   assign chain[0] = first;

   // One register level per step, one multiply in flight per step
   for (genvar i = 0; i < MUL_STAGES; i++) begin : g_step
      mul_stage #(
         .WIDTH      (WIDTH),
         .MUL_STAGES (MUL_STAGES)
      ) i_mul_stage (
         .clk      (clk),
         .rst      (rst),
         .in_step  (chain[i]),
         .out_step (chain[i+1])
      );
   end

   assign last_s = chain[MUL_STAGES];

   always_comb begin
      res.valid = last_s.valid;
      res.rd    = last_s.rd;
      res.data  = last_s.sum;
   end

   assign mul_res = res;

endmodule

// ==== rtl/retire_stage.sv ====
`timescale 1ns/100ps

module retire_stage #(
   parameter int WIDTH = 16
) (
   input  logic                                    clk,
   input  logic                                    rst,
   input  logic [core_pkg::RESULT_HDR_W+WIDTH-1:0] alu_res,
   input  logic [core_pkg::RESULT_HDR_W+WIDTH-1:0] mul_res,
   output logic                                    wr_en,
   output logic [core_pkg::REG_ADDR_W-1:0]         wr_addr,
   output logic [WIDTH-1:0]                        wr_data,
   output logic                                    retire_valid,
   output core_pkg::retire_t                       retire
);
   import core_pkg::*;

   typedef struct packed {
      logic                  valid;
      logic [REG_ADDR_W-1:0] rd;
      logic [WIDTH-1:0]      data;
   } result_t;

   result_t alu_r;
   result_t mul_r;

   assign alu_r = alu_res;
   assign mul_r = mul_res;

   // Decode reserves retire slots, so at most one side is valid
   assign wr_en   = alu_r.valid || mul_r.valid;
   assign wr_addr = alu_r.valid ? alu_r.rd : mul_r.rd;
   assign wr_data = alu_r.valid ? alu_r.data : mul_r.data;

   // Same value as the register write, one edge later on the outside
   always_ff @(posedge clk) begin
      retire.dest <= wr_addr;
      retire.data <= DATA_W'(wr_data);
      if (rst) retire_valid <= 1'b0;
      else     retire_valid <= wr_en;
   end

endmodule

// ==== rtl/exec_core.sv ====
`timescale 1ns/100ps

module exec_core #(
   parameter int WIDTH      = core_pkg::DATA_W,
   parameter int MUL_STAGES = 4               // Must divide WIDTH
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              instr_valid,
   input  core_pkg::instr_t  instr,
   output logic              stall,
   output logic              retire_valid,
   output core_pkg::retire_t retire
);
   import core_pkg::*;

   logic [REG_ADDR_W-1:0]          rd_addr_a;
   logic [REG_ADDR_W-1:0]          rd_addr_b;
   logic [WIDTH-1:0]               rd_data_a;
   logic [WIDTH-1:0]               rd_data_b;
   logic                           wr_en;
   logic [REG_ADDR_W-1:0]          wr_addr;
   logic [WIDTH-1:0]               wr_data;
   logic [ISSUE_HDR_W+2*WIDTH-1:0] alu_issue;
   logic [ISSUE_HDR_W+2*WIDTH-1:0] mul_issue;
   logic [RESULT_HDR_W+WIDTH-1:0]  alu_res;
   logic [RESULT_HDR_W+WIDTH-1:0]  mul_res;

   decode_stage #(
      .WIDTH      (WIDTH),
      .MUL_STAGES (MUL_STAGES)
   ) i_decode (
      .clk         (clk),
      .rst         (rst),
      .instr_valid (instr_valid),
      .instr       (instr),
      .stall       (stall),
      .rd_addr_a   (rd_addr_a),
      .rd_addr_b   (rd_addr_b),
      .rd_data_a   (rd_data_a),
      .rd_data_b   (rd_data_b),
      .wr_en       (wr_en),       // Scoreboard clear
      .wr_addr     (wr_addr),
      .alu_issue   (alu_issue),
      .mul_issue   (mul_issue)
   );

   regfile #(
      .WIDTH (WIDTH)
   ) i_regfile (
      .clk       (clk),
      .rst       (rst),
      .rd_addr_a (rd_addr_a),
      .rd_addr_b (rd_addr_b),
      .wr_en     (wr_en),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b)
   );

   alu_stage #(
      .WIDTH (WIDTH)
   ) i_alu (
      .clk       (clk),
      .rst       (rst),
      .alu_issue (alu_issue),
      .alu_res   (alu_res)
   );

   mul_pipe #(
      .WIDTH      (WIDTH),
      .MUL_STAGES (MUL_STAGES)
   ) i_mul (
      .clk       (clk),
      .rst       (rst),
      .mul_issue (mul_issue),
      .mul_res   (mul_res)
   );

   retire_stage #(
      .WIDTH (WIDTH)
   ) i_retire (
      .clk          (clk),
      .rst          (rst),
      .alu_res      (alu_res),
      .mul_res      (mul_res),
      .wr_en        (wr_en),
      .wr_addr      (wr_addr),
      .wr_data      (wr_data),
      .retire_valid (retire_valid),
      .retire       (retire)
   );

endmodule

// ==== testbench/exec_core_asserts.sv ====
`timescale 1ns/100ps

module exec_core_asserts #(
   parameter int MUL_STAGES = 4
) (
   input logic             clk,
   input logic             rst,
   input logic             instr_valid,
   input core_pkg::instr_t instr,
   input logic             stall,
   input logic             retire_valid
);
   import core_pkg::*;

   logic accept;
   logic alu_accept;
   logic mul_accept;
   int   rst_fails   = 0;
   int   alu_fails   = 0;
   int   mul_fails   = 0;
   int   stall_fails = 0;
   int   fail_count;

   assign accept     = instr_valid && !stall;
   assign alu_accept = accept && (instr.opcode <= OP_LDI);   // ADD through LDI
   assign mul_accept = accept && (instr.opcode == OP_MUL);
   assign fail_count = rst_fails + alu_fails + mul_fails + stall_fails;

   // Retire register is cleared by every reset edge
   assert property (@(posedge clk) $past(rst) |-> !retire_valid)
      else begin
         $error("retire_valid high in the cycle after a reset edge");
         rst_fails++;
      end

   // Retire loads 2 edges after acceptance and is sampled at the edge after that
   assert property (@(posedge clk) disable iff (rst) $past(alu_accept, 3) |-> retire_valid)
      else begin
         $error("accepted ALU op did not retire after 2 cycles");
         alu_fails++;
      end

   assert property (@(posedge clk) disable iff (rst)
                    $past(mul_accept, MUL_STAGES + 2) |-> retire_valid)
      else begin
         $error("accepted MUL did not retire after MUL_STAGES plus 1 cycles");
         mul_fails++;
      end

   assert property (@(posedge clk) !instr_valid |-> !stall)
      else begin
         $error("stall high with no instruction presented");
         stall_fails++;
      end

endmodule

// ==== testbench/tb_exec_core.sv ====
`timescale 1ns/100ps

module tb_exec_core;
   import core_pkg::*;

   localparam int WIDTH       = 16;
   localparam int MUL_STAGES  = 4;
   localparam int PERIOD      = 40;
   localparam int STALL_LIMIT = 20;   // Cycles well past the longest hazard
   localparam int DRAIN_LIMIT = 40;

   logic    clk;
   logic    rst;
   logic    instr_valid;
   instr_t  instr;
   logic    stall;
   logic    retire_valid;
   retire_t retire;

   logic [WIDTH-1:0] model [NREGS];
   logic [WIDTH-1:0] want_q [NREGS][$];   // Expected values per destination in program order
   logic [31:0]      lfsr = 32'hbfa2_6d5c;
   logic             timed_out = 1'b0;
   int               errors = 0;
   int               mismatches = 0;
   int               accepted = 0;
   int               retired = 0;
   int               tests = 0;
   int               test_start = 0;

   exec_core #(
      .WIDTH      (WIDTH),
      .MUL_STAGES (MUL_STAGES)
   ) i_dut (
      .clk          (clk),
      .rst          (rst),
      .instr_valid  (instr_valid),
      .instr        (instr),
      .stall        (stall),
      .retire_valid (retire_valid),
      .retire       (retire)
   );

   bind exec_core exec_core_asserts #(
      .MUL_STAGES (MUL_STAGES)
   ) i_asserts (
      .clk          (clk),
      .rst          (rst),
      .instr_valid  (instr_valid),
      .instr        (instr),
      .stall        (stall),
      .retire_valid (retire_valid)
   );

   initial begin
      clk = 1'b0;
      forever #(PERIOD/2) clk = ~clk;
   end

   // Galois form of x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [7:0] rand_bits(input int n);
      logic [7:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[6:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic instr_t make_instr(input logic [2:0] op, input logic [2:0] rd,
                                         input logic [2:0] rs1, input logic [2:0] rs2,
                                         input logic [7:0] imm);
      instr_t ins;
      ins        = '0;
      ins.opcode = opcode_e'(op);
      ins.rd     = rd;
      if (op == OP_LDI) begin
         ins.args.ri.imm = imm;
      end else begin
         ins.args.rr.rs1 = rs1;
         ins.args.rr.rs2 = rs2;
      end
      return ins;
   endfunction

   function automatic logic [WIDTH-1:0] model_op(input logic [2:0] op, input logic [WIDTH-1:0] a,
                                                 input logic [WIDTH-1:0] b, input logic [7:0] imm);
      case (op)
         OP_ADD:  return a + b;
         OP_SUB:  return a - b;
         OP_AND:  return a & b;
         OP_OR:   return a | b;
         OP_XOR:  return a ^ b;
         OP_LDI:  return {{(WIDTH-8){1'b0}}, imm};
         OP_MUL:  return a * b;   // Low WIDTH bits of the product
         default: return '0;
      endcase
   endfunction

   function automatic int outstanding();
      int n;
      n = 0;
      for (int r = 0; r < NREGS; r++) begin
         n += want_q[r].size();
      end
      return n;
   endfunction

   function automatic int total_errors();
      return errors + mismatches + i_dut.i_asserts.fail_count;
   endfunction

   // Holds the instruction until the DUT takes it and counts the stalled cycles
   task automatic issue(input logic [2:0] op, input logic [2:0] rd, input logic [2:0] rs1,
                        input logic [2:0] rs2, input logic [7:0] imm, output int stalls);
      logic [WIDTH-1:0] value;
      stalls = 0;
      if (!timed_out) begin
         @(negedge clk);
         instr_valid = 1'b1;
         instr       = make_instr(op, rd, rs1, rs2, imm);
         #(PERIOD/4);
         while (stall && stalls < STALL_LIMIT) begin
            stalls++;
            @(negedge clk);
            #(PERIOD/4);
         end
         if (stall) begin
            $display("Timeout: instruction held in stall for %0d cycles at %0t", stalls, $time);
            errors++;
            timed_out = 1'b1;
         end else begin
            if (op <= OP_MUL) begin   // Code 7 writes nothing
               value     = model_op(op, model[rs1], model[rs2], imm);
               model[rd] = value;
               want_q[rd].push_back(value);
               accepted++;
            end
            @(posedge clk);
         end
      end
   endtask

   task automatic idle(input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         instr_valid = 1'b0;
      end
   endtask

   task automatic drain();
      int waited;
      waited = 0;
      idle(1);
      while (outstanding() != 0 && waited < DRAIN_LIMIT && !timed_out) begin
         @(negedge clk);
         waited++;
      end
      if (outstanding() != 0 && !timed_out) begin
         $display("Timeout: %0d accepted results never retired", outstanding());
         errors++;
         timed_out = 1'b1;
      end
   endtask

   task automatic check_stalled(input int stalls, input string what);
      assert (stalls > 0 || timed_out)
         else begin
            $display("%s was accepted without a stall at %0t", what, $time);
            errors++;
         end
   endtask

   task automatic end_test(input string name);
      drain();
      tests++;
      $display("Test %0d %s: %0d errors", tests, name, total_errors() - test_start);
      test_start = total_errors();
   endtask

   // Compares each retire with the oldest expected value for its register
   always @(negedge clk) begin : check_retire
      logic [WIDTH-1:0] want;
      if (!rst && retire_valid) begin
         retired++;
         if (want_q[retire.dest].size() == 0) begin
            $display("Retire to r%0d at %0t has no accepted instruction behind it",
                     retire.dest, $time);
            mismatches++;
         end else begin
            want = want_q[retire.dest].pop_front();
            assert (retire.data == want)
               else begin
                  $display("FAILED %0t retire.data got %h expected %h", $time, retire.data, want);
                  mismatches++;
               end
         end
      end
   end

   initial begin
      int         st;
      logic [2:0] op;
      logic [2:0] a;
      logic [2:0] b;
      logic [2:0] d;
      logic [7:0] imm;
      rst         = 1'b1;
      instr_valid = 1'b0;
      instr       = '0;
      for (int r = 0; r < NREGS; r++) begin
         model[r] = '0;
      end
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      repeat (3) begin
         @(negedge clk);
         assert (!retire_valid)
            else begin
               $display("FAILED %0t retire_valid got %b expected 0", $time, retire_valid);
               errors++;
            end
      end
      for (int r = 0; r < NREGS; r++) begin
         issue(OP_LDI, 3'(r), 3'd0, 3'd0, rand_bits(8), st);
      end
      end_test("load immediates");

      // Sources in r0 to r3 and results in r4 to r7
      for (int i = 0; i < 16; i++) begin
         a = 3'(rand_bits(2));
         b = 3'(rand_bits(2));
         do begin
            op = 3'(rand_bits(3));
         end while (op > 3'd4);
         issue(op, 3'(4 + i % 4), a, b, 8'd0, st);
      end
      end_test("ALU operations");

      for (int i = 0; i < 4; i++) begin
         issue(OP_MUL, 3'(4 + i), 3'(i), 3'((i + 1) % 4), 8'd0, st);
      end
      issue(OP_MUL, 3'd6, 3'd4, 3'd5, 8'd0, st);   // Wide operands make the product wrap
      end_test("multiply");

      issue(OP_ADD, 3'd1, 3'd0, 3'd1, 8'd0, st);
      issue(OP_XOR, 3'd2, 3'd1, 3'd0, 8'd0, st);
      check_stalled(st, "XOR reading a pending r1");
      issue(OP_SUB, 3'd3, 3'd0, 3'd2, 8'd0, st);
      issue(OP_LDI, 3'd3, 3'd0, 3'd0, rand_bits(8), st);
      check_stalled(st, "LDI overwriting a pending r3");
      issue(OP_MUL, 3'd5, 3'd3, 3'd2, 8'd0, st);
      issue(OP_ADD, 3'd6, 3'd5, 3'd3, 8'd0, st);
      check_stalled(st, "ADD reading a multiply result in flight");
      end_test("dependent chains");

      // Fillers keep the last op exactly MUL_STAGES-1 cycles behind the MUL
      issue(OP_MUL, 3'd4, 3'd0, 3'd1, 8'd0, st);
      for (int k = 0; k < MUL_STAGES - 2; k++) begin
         issue(OP_LDI, 3'(k + 1), 3'd0, 3'd0, rand_bits(8), st);
      end
      issue(OP_LDI, 3'd7, 3'd0, 3'd0, rand_bits(8), st);
      check_stalled(st, "ALU op in the multiply retire slot");
      end_test("retire collision");

      for (int i = 0; i < 200; i++) begin
         op  = 3'(rand_bits(3));
         d   = 3'(rand_bits(3));
         a   = 3'(rand_bits(3));
         b   = 3'(rand_bits(3));
         imm = rand_bits(8);
         issue(op, d, a, b, imm, st);
      end
      end_test("random stream");

      assert (retired == accepted)
         else begin
            $display("%0d writing instructions were accepted but %0d retired", accepted, retired);
            errors++;
         end
      $display("Tests %0d, accepted %0d, retired %0d, errors %0d",
               tests, accepted, retired, total_errors());
      if (total_errors() == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// ==== files.f ====
rtl/core_pkg.sv
rtl/regfile.sv
rtl/decode_stage.sv
rtl/alu_stage.sv
rtl/mul_stage.sv
rtl/mul_pipe.sv
rtl/retire_stage.sv
rtl/exec_core.sv
testbench/exec_core_asserts.sv
testbench/tb_exec_core.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --assert -j 0
TOP       := tb_exec_core
FILELIST  := files.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
LOG       := sim.log
PASS_MSG  := Done: no errors
SIM_ARGS  := +verilator+error+limit+1000

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
